/* src/predecode_pkg.sv */
//////////////////////////////
// pre-decode shared definitions
// opcode constants, kinds and control types
//////////////////////////////
package predecode_pkg;

    localparam int reg_addr_w = 5;
    localparam int xlen = 32;
    localparam logic [reg_addr_w-1:0] link_reg = 5'd1;

    // top bit index of each opcode field value
    localparam int opc22_hi = 21;
    localparam int opc17_hi = 16;
    localparam int opc10_hi = 9;
    localparam int opc7_hi = 6;
    localparam int opc6_hi = 5;

    //////////////////////////////
    // opcodes in inst[31:15]
    localparam logic [opc17_hi:0] opc_add_w = 17'h00020;
    localparam logic [opc17_hi:0] opc_sub_w = 17'h00022;
    localparam logic [opc17_hi:0] opc_slt = 17'h00024;
    localparam logic [opc17_hi:0] opc_sltu = 17'h00025;
    localparam logic [opc17_hi:0] opc_nor = 17'h00028;
    localparam logic [opc17_hi:0] opc_and = 17'h00029;
    localparam logic [opc17_hi:0] opc_or = 17'h0002a;
    localparam logic [opc17_hi:0] opc_xor = 17'h0002b;
    localparam logic [opc17_hi:0] opc_sll_w = 17'h0002e;
    localparam logic [opc17_hi:0] opc_srl_w = 17'h0002f;
    localparam logic [opc17_hi:0] opc_sra_w = 17'h00030;
    localparam logic [opc17_hi:0] opc_slli_w = 17'h00081;
    localparam logic [opc17_hi:0] opc_srli_w = 17'h00089;
    localparam logic [opc17_hi:0] opc_srai_w = 17'h00091;
    // opcodes in inst[31:22]
    localparam logic [opc10_hi:0] opc_slti = 10'h008;
    localparam logic [opc10_hi:0] opc_sltui = 10'h009;
    localparam logic [opc10_hi:0] opc_addi_w = 10'h00a;
    localparam logic [opc10_hi:0] opc_andi = 10'h00d;
    localparam logic [opc10_hi:0] opc_ori = 10'h00e;
    localparam logic [opc10_hi:0] opc_xori = 10'h00f;
    localparam logic [opc10_hi:0] opc_ld_b = 10'h0a0;
    localparam logic [opc10_hi:0] opc_ld_h = 10'h0a1;
    localparam logic [opc10_hi:0] opc_ld_w = 10'h0a2;
    localparam logic [opc10_hi:0] opc_st_b = 10'h0a4;
    localparam logic [opc10_hi:0] opc_st_h = 10'h0a5;
    localparam logic [opc10_hi:0] opc_st_w = 10'h0a6;
    // opcodes in inst[31:25] and inst[31:26]
    localparam logic [opc7_hi:0] opc_lu12i_w = 7'h0a;
    localparam logic [opc7_hi:0] opc_pcaddu12i = 7'h0e;
    localparam logic [opc6_hi:0] opc_jirl = 6'h13;
    localparam logic [opc6_hi:0] opc_b = 6'h14;
    localparam logic [opc6_hi:0] opc_bl = 6'h15;
    localparam logic [opc6_hi:0] opc_beq = 6'h16;
    localparam logic [opc6_hi:0] opc_bne = 6'h17;
    localparam logic [opc6_hi:0] opc_blt = 6'h18;
    localparam logic [opc6_hi:0] opc_bge = 6'h19;
    localparam logic [opc6_hi:0] opc_bltu = 6'h1a;
    localparam logic [opc6_hi:0] opc_bgeu = 6'h1b;

    //////////////////////////////
    // invalid sits at zero so an all-zero kind means no instruction
    typedef enum logic [5:0] {
        kind_invalid,
        kind_add_w, kind_sub_w, kind_slt, kind_sltu, kind_nor, kind_and,
        kind_or, kind_xor, kind_sll_w, kind_srl_w, kind_sra_w,
        kind_slli_w, kind_srli_w, kind_srai_w,
        kind_addi_w, kind_slti, kind_sltui, kind_andi, kind_ori, kind_xori,
        kind_lu12i_w, kind_pcaddu12i,
        kind_jirl, kind_b, kind_bl, kind_beq, kind_bne,
        kind_blt, kind_bge, kind_bltu, kind_bgeu,
        kind_ld_b, kind_ld_h, kind_ld_w, kind_st_b, kind_st_h, kind_st_w
    } inst_kind_t;

    // operand selects, one-hot
    typedef enum logic [1:0] {src1_none = 2'b00, src1_pc = 2'b01, src1_reg = 2'b10} src1_sel_t;
    typedef enum logic [2:0] {
        src2_none = 3'b000, src2_imm = 3'b001, src2_reg = 3'b010, src2_four = 3'b100
    } src2_sel_t;
    typedef enum logic [1:0] {mem_word = 2'b00, mem_half = 2'b01, mem_byte = 2'b10} mem_width_t;
    typedef enum logic [1:0] {
        valid_none = 2'b00, valid_exe = 2'b01, valid_mem = 2'b10
    } valid_stage_t;

    // add in the top bit, lui in bit 0
    typedef struct packed {
        logic op_add;
        logic op_sub;
        logic op_slt;
        logic op_sltu;
        logic op_and;
        logic op_nor;
        logic op_or;
        logic op_xor;
        logic op_sll;
        logic op_srl;
        logic op_sra;
        logic op_lui;
    } alu_op_t;

endpackage

/* src/stage_if.sv */
//////////////////////////////
// held instruction from stage register to decoders
//////////////////////////////
`timescale 1ns/1ps

interface stage_if;
    // held entry
    logic valid;
    logic [predecode_pkg::xlen-1:0] pc;
    logic [predecode_pkg::xlen-1:0] inst;
    // downstream take, driven from out_ready
    logic ready;

    // stage register side
    modport producer (output valid, output pc, output inst, input ready);

    // decoder side, read only
    modport consumer (input valid, input pc, input inst, input ready);
endinterface

/* src/stage_reg.sv */
//////////////////////////////
// pre-decode stage register
// valid flag, pc and word with allow-in
//////////////////////////////
`timescale 1ns/1ps

module stage_reg (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    input  logic [predecode_pkg::xlen-1:0] in_pc,
    input  logic [predecode_pkg::xlen-1:0] in_inst,
    output logic allow_in,
    stage_if.producer stg
);
    logic accept;

    // room when empty, or when the held entry leaves this edge
    assign allow_in = ~stg.valid | stg.ready;
    assign accept = in_valid & allow_in;

    // valid drops when taken with nothing behind it
    always_ff @(posedge clk)
    begin
        if (reset)
            stg.valid <= 1'b0;
        else if (allow_in)
            stg.valid <= in_valid;
    end

    // word comes up zero, which classifies as invalid
    always_ff @(posedge clk)
    begin
        if (reset)
            stg.inst <= '0;
        else if (accept)
            stg.inst <= in_inst;
    end

    // pc only loads on accept, held under back-pressure
    always_ff @(posedge clk)
    begin
        if (accept)
            stg.pc <= in_pc;
    end
endmodule

/* src/inst_classifier.sv */
//////////////////////////////
// instruction classifier
// opcode fields to instruction kind
//////////////////////////////
`timescale 1ns/1ps

module inst_classifier (
    stage_if.consumer stg,
    output predecode_pkg::inst_kind_t kind
);
    logic [predecode_pkg::opc22_hi:0] op22;
    logic [predecode_pkg::opc17_hi:0] op17;
    logic [predecode_pkg::opc10_hi:0] op10;
    logic [predecode_pkg::opc7_hi:0] op7;
    logic [predecode_pkg::opc6_hi:0] op6;

    // fields nest, all start at bit 31
    assign op22 = stg.inst[31:10];
    assign op17 = op22[predecode_pkg::opc22_hi -: predecode_pkg::opc17_hi + 1];
    assign op10 = op22[predecode_pkg::opc22_hi -: predecode_pkg::opc10_hi + 1];
    assign op7 = op22[predecode_pkg::opc22_hi -: predecode_pkg::opc7_hi + 1];
    assign op6 = op22[predecode_pkg::opc22_hi -: predecode_pkg::opc6_hi + 1];

    // kept encodings never hit two fields at once
    always_comb
    begin
        kind = predecode_pkg::kind_invalid;
        // register and shift-immediate forms
        case (op17)
            predecode_pkg::opc_add_w: kind = predecode_pkg::kind_add_w;
            predecode_pkg::opc_sub_w: kind = predecode_pkg::kind_sub_w;
            predecode_pkg::opc_slt: kind = predecode_pkg::kind_slt;
            predecode_pkg::opc_sltu: kind = predecode_pkg::kind_sltu;
            predecode_pkg::opc_nor: kind = predecode_pkg::kind_nor;
            predecode_pkg::opc_and: kind = predecode_pkg::kind_and;
            predecode_pkg::opc_or: kind = predecode_pkg::kind_or;
            predecode_pkg::opc_xor: kind = predecode_pkg::kind_xor;
            predecode_pkg::opc_sll_w: kind = predecode_pkg::kind_sll_w;
            predecode_pkg::opc_srl_w: kind = predecode_pkg::kind_srl_w;
            predecode_pkg::opc_sra_w: kind = predecode_pkg::kind_sra_w;
            predecode_pkg::opc_slli_w: kind = predecode_pkg::kind_slli_w;
            predecode_pkg::opc_srli_w: kind = predecode_pkg::kind_srli_w;
            predecode_pkg::opc_srai_w: kind = predecode_pkg::kind_srai_w;
            default: ;
        endcase
        // 12-bit immediate alu ops and memory
        case (op10)
            predecode_pkg::opc_slti: kind = predecode_pkg::kind_slti;
            predecode_pkg::opc_sltui: kind = predecode_pkg::kind_sltui;
            predecode_pkg::opc_addi_w: kind = predecode_pkg::kind_addi_w;
            predecode_pkg::opc_andi: kind = predecode_pkg::kind_andi;
            predecode_pkg::opc_ori: kind = predecode_pkg::kind_ori;
            predecode_pkg::opc_xori: kind = predecode_pkg::kind_xori;
            predecode_pkg::opc_ld_b: kind = predecode_pkg::kind_ld_b;
            predecode_pkg::opc_ld_h: kind = predecode_pkg::kind_ld_h;
            predecode_pkg::opc_ld_w: kind = predecode_pkg::kind_ld_w;
            predecode_pkg::opc_st_b: kind = predecode_pkg::kind_st_b;
            predecode_pkg::opc_st_h: kind = predecode_pkg::kind_st_h;
            predecode_pkg::opc_st_w: kind = predecode_pkg::kind_st_w;
            default: ;
        endcase
        // 20-bit upper immediates
        case (op7)
            predecode_pkg::opc_lu12i_w: kind = predecode_pkg::kind_lu12i_w;
            predecode_pkg::opc_pcaddu12i: kind = predecode_pkg::kind_pcaddu12i;
            default: ;
        endcase
        // branches and jumps
        case (op6)
            predecode_pkg::opc_jirl: kind = predecode_pkg::kind_jirl;
            predecode_pkg::opc_b: kind = predecode_pkg::kind_b;
            predecode_pkg::opc_bl: kind = predecode_pkg::kind_bl;
            predecode_pkg::opc_beq: kind = predecode_pkg::kind_beq;
            predecode_pkg::opc_bne: kind = predecode_pkg::kind_bne;
            predecode_pkg::opc_blt: kind = predecode_pkg::kind_blt;
            predecode_pkg::opc_bge: kind = predecode_pkg::kind_bge;
            predecode_pkg::opc_bltu: kind = predecode_pkg::kind_bltu;
            predecode_pkg::opc_bgeu: kind = predecode_pkg::kind_bgeu;
            default: ;
        endcase
    end
endmodule

/* src/operand_decoder.sv */
//////////////////////////////
// operand decoder
// register numbers, immediate, operand selects
//////////////////////////////
`timescale 1ns/1ps

module operand_decoder (
    stage_if.consumer stg,
    input  predecode_pkg::inst_kind_t kind,
    output logic [predecode_pkg::reg_addr_w-1:0] rf_r_addr1,
    output logic [predecode_pkg::reg_addr_w-1:0] rf_r_addr2,
    output logic [predecode_pkg::reg_addr_w-1:0] rf_w_addr,
    output logic [predecode_pkg::xlen-1:0] imm,
    output predecode_pkg::src1_sel_t src1_sel,
    output predecode_pkg::src2_sel_t src2_sel
);
    logic [predecode_pkg::reg_addr_w-1:0] rk;
    logic [predecode_pkg::reg_addr_w-1:0] rj;
    logic [predecode_pkg::reg_addr_w-1:0] rd;
    logic [predecode_pkg::xlen-1:0] imm_si12;
    logic [predecode_pkg::xlen-1:0] imm_ui12;
    logic [predecode_pkg::xlen-1:0] imm_ui5;
    logic [predecode_pkg::xlen-1:0] imm_u20;
    logic [predecode_pkg::xlen-1:0] imm_offs16;
    logic [predecode_pkg::xlen-1:0] imm_offs26;

    assign rk = stg.inst[14:10];
    assign rj = stg.inst[9:5];
    assign rd = stg.inst[4:0];

    //////////////////////////////
    // the six immediate formats
    assign imm_si12 = {{20{stg.inst[21]}}, stg.inst[21:10]};
    assign imm_ui12 = {20'b0, stg.inst[21:10]};
    assign imm_ui5 = {27'b0, stg.inst[14:10]};
    assign imm_u20 = {stg.inst[24:5], 12'b0};
    assign imm_offs16 = {{14{stg.inst[25]}}, stg.inst[25:10], 2'b0};
    // offs26 high part sits in the low field
    assign imm_offs26 = {{4{stg.inst[9]}}, stg.inst[9:0], stg.inst[25:10], 2'b0};

    //////////////////////////////
    always_comb
    begin
        // unused addresses read as r0
        rf_r_addr1 = '0;
        rf_r_addr2 = '0;
        rf_w_addr = '0;
        imm = '0;
        src1_sel = predecode_pkg::src1_none;
        src2_sel = predecode_pkg::src2_none;
        case (kind)
            predecode_pkg::kind_add_w, predecode_pkg::kind_sub_w, predecode_pkg::kind_slt,
            predecode_pkg::kind_sltu, predecode_pkg::kind_and, predecode_pkg::kind_or,
            predecode_pkg::kind_nor, predecode_pkg::kind_xor, predecode_pkg::kind_sll_w,
            predecode_pkg::kind_srl_w, predecode_pkg::kind_sra_w:
            begin
                // rk first, rj second
                rf_r_addr1 = rk;
                rf_r_addr2 = rj;
                rf_w_addr = rd;
                src1_sel = predecode_pkg::src1_reg;
                src2_sel = predecode_pkg::src2_reg;
            end
            predecode_pkg::kind_slli_w, predecode_pkg::kind_srli_w, predecode_pkg::kind_srai_w,
            predecode_pkg::kind_addi_w, predecode_pkg::kind_slti, predecode_pkg::kind_sltui,
            predecode_pkg::kind_andi, predecode_pkg::kind_ori, predecode_pkg::kind_xori,
            predecode_pkg::kind_ld_b, predecode_pkg::kind_ld_h, predecode_pkg::kind_ld_w,
            predecode_pkg::kind_jirl:
            begin
                rf_r_addr1 = rj;
                rf_w_addr = rd;
                src1_sel = predecode_pkg::src1_reg;
                src2_sel = predecode_pkg::src2_imm;
            end
            predecode_pkg::kind_st_b, predecode_pkg::kind_st_h, predecode_pkg::kind_st_w:
            begin
                // rd carries the store data
                rf_r_addr1 = rj;
                rf_r_addr2 = rd;
                src1_sel = predecode_pkg::src1_reg;
                src2_sel = predecode_pkg::src2_imm;
            end
            predecode_pkg::kind_lu12i_w, predecode_pkg::kind_pcaddu12i:
            begin
                rf_w_addr = rd;
                src2_sel = predecode_pkg::src2_imm;
                if (kind == predecode_pkg::kind_pcaddu12i)
                    src1_sel = predecode_pkg::src1_pc;
            end
            predecode_pkg::kind_beq, predecode_pkg::kind_bne, predecode_pkg::kind_blt,
            predecode_pkg::kind_bge, predecode_pkg::kind_bltu, predecode_pkg::kind_bgeu:
            begin
                // compare rj with rd, only beq/bne route rd through src2
                rf_r_addr1 = rj;
                rf_r_addr2 = rd;
                src1_sel = predecode_pkg::src1_reg;
                if (kind == predecode_pkg::kind_beq || kind == predecode_pkg::kind_bne)
                    src2_sel = predecode_pkg::src2_reg;
            end
            predecode_pkg::kind_bl:
            begin
                // link value is pc + 4
                rf_w_addr = predecode_pkg::link_reg;
                src1_sel = predecode_pkg::src1_pc;
                src2_sel = predecode_pkg::src2_four;
            end
            default: ;
        endcase

        // immediate by format group
        case (kind)
            predecode_pkg::kind_addi_w, predecode_pkg::kind_slti, predecode_pkg::kind_sltui,
            predecode_pkg::kind_ld_b, predecode_pkg::kind_ld_h, predecode_pkg::kind_ld_w,
            predecode_pkg::kind_st_b, predecode_pkg::kind_st_h, predecode_pkg::kind_st_w:
                imm = imm_si12;
            predecode_pkg::kind_andi, predecode_pkg::kind_ori, predecode_pkg::kind_xori:
                imm = imm_ui12;
            predecode_pkg::kind_slli_w, predecode_pkg::kind_srli_w, predecode_pkg::kind_srai_w:
                imm = imm_ui5;
            predecode_pkg::kind_lu12i_w, predecode_pkg::kind_pcaddu12i:
                imm = imm_u20;
            predecode_pkg::kind_jirl, predecode_pkg::kind_beq, predecode_pkg::kind_bne,
            predecode_pkg::kind_blt, predecode_pkg::kind_bge, predecode_pkg::kind_bltu,
            predecode_pkg::kind_bgeu:
                imm = imm_offs16;
            predecode_pkg::kind_b, predecode_pkg::kind_bl:
                imm = imm_offs26;
            default: ;
        endcase
    end
endmodule

/* src/control_decoder.sv */
//////////////////////////////
// control decoder
// alu op, memory, write-back, forward stage
//////////////////////////////
`timescale 1ns/1ps

module control_decoder (
    input  predecode_pkg::inst_kind_t kind,
    output predecode_pkg::alu_op_t alu_op,
    output logic mem_en,
    output logic mem_we,
    output predecode_pkg::mem_width_t mem_width,
    output logic rf_w_en,
    output logic rf_w_from_mem,
    output predecode_pkg::valid_stage_t valid_stage
);
    //////////////////////////////
    // alu operation, register and immediate forms share a bit
    always_comb
    begin
        alu_op = '0;
        case (kind)
            // address and link arithmetic all use add
            predecode_pkg::kind_add_w, predecode_pkg::kind_addi_w, predecode_pkg::kind_jirl,
            predecode_pkg::kind_bl, predecode_pkg::kind_pcaddu12i,
            predecode_pkg::kind_ld_b, predecode_pkg::kind_ld_h, predecode_pkg::kind_ld_w,
            predecode_pkg::kind_st_b, predecode_pkg::kind_st_h, predecode_pkg::kind_st_w:
                alu_op.op_add = 1'b1;
            predecode_pkg::kind_sub_w: alu_op.op_sub = 1'b1;
            predecode_pkg::kind_slt, predecode_pkg::kind_slti: alu_op.op_slt = 1'b1;
            predecode_pkg::kind_sltu, predecode_pkg::kind_sltui: alu_op.op_sltu = 1'b1;
            predecode_pkg::kind_and, predecode_pkg::kind_andi: alu_op.op_and = 1'b1;
            predecode_pkg::kind_nor: alu_op.op_nor = 1'b1;
            predecode_pkg::kind_or, predecode_pkg::kind_ori: alu_op.op_or = 1'b1;
            predecode_pkg::kind_xor, predecode_pkg::kind_xori: alu_op.op_xor = 1'b1;
            predecode_pkg::kind_sll_w, predecode_pkg::kind_slli_w: alu_op.op_sll = 1'b1;
            predecode_pkg::kind_srl_w, predecode_pkg::kind_srli_w: alu_op.op_srl = 1'b1;
            predecode_pkg::kind_sra_w, predecode_pkg::kind_srai_w: alu_op.op_sra = 1'b1;
            predecode_pkg::kind_lu12i_w: alu_op.op_lui = 1'b1;
            default: ;
        endcase
    end

    //////////////////////////////
    // memory and write-back
    always_comb
    begin
        mem_en = 1'b0;
        mem_we = 1'b0;
        mem_width = predecode_pkg::mem_word;
        rf_w_en = 1'b0;
        rf_w_from_mem = 1'b0;
        valid_stage = predecode_pkg::valid_none;
        case (kind)
            predecode_pkg::kind_ld_b, predecode_pkg::kind_ld_h, predecode_pkg::kind_ld_w:
            begin
                // load data only exists after mem
                mem_en = 1'b1;
                rf_w_en = 1'b1;
                rf_w_from_mem = 1'b1;
                valid_stage = predecode_pkg::valid_mem;
            end
            predecode_pkg::kind_st_b, predecode_pkg::kind_st_h, predecode_pkg::kind_st_w:
            begin
                mem_en = 1'b1;
                mem_we = 1'b1;
            end
            // branches and invalid write nothing
            predecode_pkg::kind_invalid, predecode_pkg::kind_b, predecode_pkg::kind_beq,
            predecode_pkg::kind_bne, predecode_pkg::kind_blt, predecode_pkg::kind_bge,
            predecode_pkg::kind_bltu, predecode_pkg::kind_bgeu: ;
            default:
            begin
                rf_w_en = 1'b1;
                valid_stage = predecode_pkg::valid_exe;
            end
        endcase
        // width from the .b/.h suffix
        case (kind)
            predecode_pkg::kind_ld_b, predecode_pkg::kind_st_b:
                mem_width = predecode_pkg::mem_byte;
            predecode_pkg::kind_ld_h, predecode_pkg::kind_st_h:
                mem_width = predecode_pkg::mem_half;
            default: ;
        endcase
    end
endmodule

/* src/predecode_top.sv */
//////////////////////////////
// pre-decode stage top
//////////////////////////////
`timescale 1ns/1ps

module predecode_top (
    input  logic clk,
    input  logic reset,
    // fetch side
    input  logic in_valid,
    input  logic [predecode_pkg::xlen-1:0] in_pc,
    input  logic [predecode_pkg::xlen-1:0] in_inst,
    output logic allow_in,
    // decode side handshake
    output logic out_valid,
    input  logic out_ready,
    output logic [predecode_pkg::xlen-1:0] out_pc,
    // decoded fields
    output predecode_pkg::inst_kind_t kind,
    output logic [predecode_pkg::reg_addr_w-1:0] rf_r_addr1,
    output logic [predecode_pkg::reg_addr_w-1:0] rf_r_addr2,
    output logic [predecode_pkg::reg_addr_w-1:0] rf_w_addr,
    output logic [predecode_pkg::xlen-1:0] imm,
    output predecode_pkg::src1_sel_t src1_sel,
    output predecode_pkg::src2_sel_t src2_sel,
    output predecode_pkg::alu_op_t alu_op,
    output logic mem_en,
    output logic mem_we,
    output predecode_pkg::mem_width_t mem_width,
    output logic rf_w_en,
    output logic rf_w_from_mem,
    output predecode_pkg::valid_stage_t valid_stage
);
    stage_if stg ();

    assign stg.ready = out_ready;
    assign out_valid = stg.valid;
    assign out_pc = stg.pc;

    // one cycle register, then pure decode fan-out
    stage_reg u_stage_reg (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_pc(in_pc),
        .in_inst(in_inst), .allow_in(allow_in), .stg(stg.producer)
    );

    inst_classifier u_classifier (.stg(stg.consumer), .kind(kind));

    operand_decoder u_operand_decoder (
        .stg(stg.consumer), .kind(kind),
        .rf_r_addr1(rf_r_addr1), .rf_r_addr2(rf_r_addr2), .rf_w_addr(rf_w_addr),
        .imm(imm), .src1_sel(src1_sel), .src2_sel(src2_sel)
    );

    control_decoder u_control_decoder (
        .kind(kind), .alu_op(alu_op), .mem_en(mem_en), .mem_we(mem_we),
        .mem_width(mem_width), .rf_w_en(rf_w_en), .rf_w_from_mem(rf_w_from_mem),
        .valid_stage(valid_stage)
    );
endmodule

/* testbench/predecode_assert.sv */
//////////////////////////////
// pre-decode handshake and control checks
//////////////////////////////
`timescale 1ns/1ps

module predecode_assert (
    input logic clk,
    input logic reset,
    input logic allow_in,
    input logic out_valid,
    input logic out_ready,
    input logic [predecode_pkg::xlen-1:0] out_pc,
    input predecode_pkg::inst_kind_t kind,
    input logic [predecode_pkg::reg_addr_w-1:0] rf_r_addr1,
    input logic [predecode_pkg::reg_addr_w-1:0] rf_r_addr2,
    input logic [predecode_pkg::reg_addr_w-1:0] rf_w_addr,
    input logic [predecode_pkg::xlen-1:0] imm,
    input predecode_pkg::src1_sel_t src1_sel,
    input predecode_pkg::src2_sel_t src2_sel,
    input predecode_pkg::alu_op_t alu_op,
    input logic mem_en,
    input logic mem_we,
    input predecode_pkg::mem_width_t mem_width,
    input logic rf_w_en,
    input logic rf_w_from_mem,
    input predecode_pkg::valid_stage_t valid_stage
);
    // every decoded field plus pc, 110 bits
    logic [109:0] decoded;

    assign decoded = {kind, rf_r_addr1, rf_r_addr2, rf_w_addr, imm, src1_sel, src2_sel,
        alu_op, mem_en, mem_we, mem_width, rf_w_en, rf_w_from_mem, valid_stage, out_pc};

    // stalled entry holds still
    assert property (@(posedge clk) disable iff (reset)
        ($past(out_valid) && !$past(out_ready)) |-> (out_valid && decoded == $past(decoded)))
        else $error("decoded outputs changed while stalled");

    assert property (@(posedge clk) disable iff (reset) mem_we |-> mem_en)
        else $error("mem_we high without mem_en");

    // empty stage always takes input
    assert property (@(posedge clk) disable iff (reset) !out_valid |-> allow_in)
        else $error("allow_in low with the stage empty");
endmodule

/* testbench/predecode_tb.sv */
//////////////////////////////
// pre-decode stage testbench
// file-driven stimulus, random gaps and back-pressure
//////////////////////////////
`timescale 1ns/1ps

module predecode_tb;
    localparam int num_tests = 23;
    // inst, pc, imm, ids, controls
    localparam int words_per_test = 5;
    localparam int timeout_cycles = 8 * num_tests + 50;

    logic clk;
    logic reset;
    logic in_valid;
    logic [predecode_pkg::xlen-1:0] in_pc;
    logic [predecode_pkg::xlen-1:0] in_inst;
    logic allow_in;
    logic out_valid;
    logic out_ready;
    logic [predecode_pkg::xlen-1:0] out_pc;
    predecode_pkg::inst_kind_t kind;
    logic [predecode_pkg::reg_addr_w-1:0] rf_r_addr1;
    logic [predecode_pkg::reg_addr_w-1:0] rf_r_addr2;
    logic [predecode_pkg::reg_addr_w-1:0] rf_w_addr;
    logic [predecode_pkg::xlen-1:0] imm;
    predecode_pkg::src1_sel_t src1_sel;
    predecode_pkg::src2_sel_t src2_sel;
    predecode_pkg::alu_op_t alu_op;
    logic mem_en;
    logic mem_we;
    predecode_pkg::mem_width_t mem_width;
    logic rf_w_en;
    logic rf_w_from_mem;
    predecode_pkg::valid_stage_t valid_stage;

    logic [31:0] test_mem [0:num_tests*words_per_test-1];
    // line numbers accepted but not yet taken
    int expect_q[$];
    int next_line;
    int checked;
    int cycles = 0;
    integer seed;

    predecode_top dut0 (.*);

    bind predecode_top predecode_assert u_assert (
        .clk(clk), .reset(reset), .allow_in(allow_in), .out_valid(out_valid),
        .out_ready(out_ready), .out_pc(out_pc), .kind(kind), .rf_r_addr1(rf_r_addr1),
        .rf_r_addr2(rf_r_addr2), .rf_w_addr(rf_w_addr), .imm(imm), .src1_sel(src1_sel),
        .src2_sel(src2_sel), .alu_op(alu_op), .mem_en(mem_en), .mem_we(mem_we),
        .mem_width(mem_width), .rf_w_en(rf_w_en), .rf_w_from_mem(rf_w_from_mem),
        .valid_stage(valid_stage)
    );

    always #2 clk = ~clk;

    //////////////////////////////
    // checking helpers
    function automatic logic [31:0] test_word(input int line, input int col);
        return test_mem[line * words_per_test + col];
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "decode check failed");
        end
    endtask

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    // one taken output against its file line
    task automatic check_outputs(input int line);
        logic [31:0] ids;
        logic [31:0] ctl;
        ids = test_word(line, 3);
        ctl = test_word(line, 4);
        compare_value("out_pc", out_pc, test_word(line, 1));
        compare_value("kind", 32'(kind), 32'(ids[31:24]));
        compare_value("rf_r_addr1", 32'(rf_r_addr1), 32'(ids[23:16]));
        compare_value("rf_r_addr2", 32'(rf_r_addr2), 32'(ids[15:8]));
        compare_value("rf_w_addr", 32'(rf_w_addr), 32'(ids[7:0]));
        compare_value("imm", imm, test_word(line, 2));
        compare_value("src1_sel", 32'(src1_sel), 32'(ctl[27:24]));
        compare_value("src2_sel", 32'(src2_sel), 32'(ctl[23:20]));
        compare_value("alu_op", 32'(alu_op), 32'(ctl[19:8]));
        // mem nibble then wb nibble
        compare_value("mem_en", 32'(mem_en), 32'(ctl[7]));
        compare_value("mem_we", 32'(mem_we), 32'(ctl[6]));
        compare_value("mem_width", 32'(mem_width), 32'(ctl[5:4]));
        compare_value("rf_w_en", 32'(rf_w_en), 32'(ctl[3]));
        compare_value("rf_w_from_mem", 32'(rf_w_from_mem), 32'(ctl[2]));
        compare_value("valid_stage", 32'(valid_stage), 32'(ctl[1:0]));
    endtask

    //////////////////////////////
    // run limit
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles)
            stop_run("timeout: not every test line came out of the stage in time");
    end

    //////////////////////////////
    initial
    begin
        logic [31:0] rnd;
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_pc = '0;
        in_inst = '0;
        out_ready = 1'b0;
        seed = 32'he9b2_84d8;
        next_line = 0;
        checked = 0;

        // kind byte ff marks a word the file never reached
        for (int i = 0; i < num_tests * words_per_test; i++)
            test_mem[i] = 32'hffff_0000 ^ i;
        $readmemh("testbench/predecode_tests.txt", test_mem);
        for (int i = 0; i < num_tests; i++)
            if (test_word(i, 3) > 32'h25ff_ffff)
                stop_run("test file holds fewer lines than expected");

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        // empty stage before any input
        compare_value("out_valid", 32'(out_valid), 32'd0);
        compare_value("allow_in", 32'(allow_in), 32'd1);
        compare_value("kind", 32'(kind), 32'(predecode_pkg::kind_invalid));

        while (checked < num_tests)
        begin
            // take at this edge
            if (out_valid && out_ready)
            begin
                if (expect_q.size() == 0)
                    stop_run("stage gave an output with no instruction pending");
                check_outputs(expect_q.pop_front());
                checked++;
            end
            // accept at this edge
            if (in_valid && allow_in)
            begin
                expect_q.push_back(next_line);
                next_line++;
            end

            rnd = $random(seed);
            // ready low about a quarter of the time
            out_ready <= (rnd[1:0] != 2'b00);
            // hold an offered word until it goes in
            if (!in_valid || allow_in)
            begin
                if (next_line < num_tests && rnd[3:2] != 2'b00)
                begin
                    in_valid <= 1'b1;
                    in_inst <= test_word(next_line, 0);
                    in_pc <= test_word(next_line, 1);
                end
                else
                    in_valid <= 1'b0;
            end
            @(posedge clk);
        end

        $display("STATUS: PASS");
        $finish;
    end
endmodule

/* testbench/predecode_tests.txt */
// in_inst pc imm {kind,rf_r_addr1,rf_r_addr2,rf_w_addr} {0,src1,src2,alu_op,mem,wb}
// mem nibble {mem_en,mem_we,mem_width}, wb nibble {rf_w_en,rf_w_from_mem,valid_stage}
00100823 1c000000 00000000 01020103 02280009 // add.w r3, r1, r2
0011316a 1c000004 00000000 020c0b0a 02240009 // sub.w r10, r11, r12
001218a4 1c000008 00000000 03060504 02220009 // slt r4, r5, r6
0012a507 1c00000c 00000000 04090807 02210009 // sltu r7, r8, r9
001477df 1c000010 00000000 051d1e1f 02204009 // nor r31, r30, r29
0015a928 1c000014 00000000 080a0908 02201009 // xor r8, r9, r10
0018460f 1c000018 00000000 0b11100f 02200209 // sra.w r15, r16, r17
0040fc62 1c00001c 0000001f 0c030002 02100809 // slli.w r2, r3, 31
004896b4 1c000020 00000005 0e150014 02100209 // srai.w r20, r21, 5
02bffcc5 1c000024 ffffffff 0f060005 02180009 // addi.w r5, r6, -1
03600149 1c000028 00000800 120a0009 02108009 // andi r9, r10, 0x800
ffffffff 1c00002c 00000000 00000000 00000000 // no kept encoding
1500002c 1c000030 80001000 1500000c 00100109 // lu12i.w r12, 0x80001
1c00246d 1c000034 00123000 1600000d 01180009 // pcaddu12i r13, 0x123
283fe1ee 1c000038 fffffff8 200f000e 021800ae // ld.b r14, r15, -8
289ff230 1c00003c 000007fc 22110010 0218008e // ld.w r16, r17, 0x7fc
29400a72 1c000040 00000002 24131200 021800d0 // st.h r18, r19, 2
29a00041 1c000044 fffff800 25020100 021800c0 // st.w r1, r2, -2048
5bfffc85 1c000048 fffffffc 1a040500 02200000 // beq r4, r5, -4
600400c7 1c00004c 00000400 1c060700 02000000 // blt r6, r7, 0x400
4e000103 1c000050 fffe0000 17080003 02180009 // jirl r3, r8, -0x20000
50000600 1c000054 f8000004 18000000 00000000 // b with high offset field set
54010001 1c000058 00040100 19000001 01480009 // bl 0x40100

/* filelist.f */
src/predecode_pkg.sv
src/stage_if.sv
src/stage_reg.sv
src/inst_classifier.sv
src/operand_decoder.sv
src/control_decoder.sv
src/predecode_top.sv
testbench/predecode_assert.sv
testbench/predecode_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the pre-decode testbench with Verilator and runs it
# exit status 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module predecode_tb -f filelist.f -o predecode_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/predecode_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1
